// ==== rtl/cache_geom_pkg.sv ====
`default_nettype none

package cache_geom_pkg;

    // fixed geometry, 4 ways x 16 sets of 32-byte lines
    localparam int num_ways    = 4;
    localparam int num_sets    = 16;
    localparam int tag_bits    = 23;
    localparam int set_bits    = 4;
    localparam int offset_bits = 5;
    localparam int line_bytes  = 32;

    typedef logic [8*line_bytes-1:0] line_t;
    typedef logic [line_bytes-1:0]   bmask_t;
    typedef logic [tag_bits-1:0]     tag_t;
    typedef logic [set_bits-1:0]     set_t;
    typedef logic [1:0]              way_t;
    typedef logic [num_ways-1:0]     way_map_t;

    // tag | set | byte offset
    typedef struct packed {
        tag_t                   tag;
        set_t                   set;
        logic [offset_bits-1:0] offset;
    } addr_fields_t;

    // ports carry the flat word, datapath reads the fields
    typedef union packed {
        logic [31:0]  flat;
        addr_fields_t f;
    } addr_u;

endpackage

`default_nettype wire

// ==== rtl/cache_bus_pkg.sv ====
`default_nettype none

package cache_bus_pkg;

    // request from the cpu side, whole line plus byte mask
    typedef struct packed {
        cache_geom_pkg::addr_u  addr;
        logic                   write;
        cache_geom_pkg::bmask_t bmask;
        cache_geom_pkg::line_t  wdata;
    } cpu_cmd_t;

    // request to memory, always line aligned
    typedef struct packed {
        cache_geom_pkg::addr_u addr;
        logic                  write;
        cache_geom_pkg::line_t wdata;
    } mem_cmd_t;

    typedef enum logic [1:0] {line_idle, line_set, line_clear} line_op_e;
    typedef enum logic [1:0] {dwe_none, dwe_hit, dwe_victim} data_we_sel_e;
    typedef enum logic {din_cpu, din_mem} din_sel_e;
    typedef enum logic {out_hit, out_victim} out_sel_e;
    typedef enum logic {addr_req, addr_victim} addr_sel_e;

    // control bundle, fsm to datapath and line state
    typedef struct packed {
        data_we_sel_e data_we_sel;
        logic         tag_we;
        din_sel_e     din_sel;
        out_sel_e     out_way_sel;
        addr_sel_e    addr_sel;
        logic         mask_en;
        line_op_e     dirty_op;
        line_op_e     valid_op;
        logic         plru_update;
    } dp_ctrl_t;

endpackage

`default_nettype wire

// ==== rtl/cache_way_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_way_array (
    input  logic                   clk,
    input  logic                   data_we_i,
    input  logic                   tag_we_i,
    input  cache_geom_pkg::set_t   set_i,
    input  cache_geom_pkg::bmask_t bmask_i,
    input  cache_geom_pkg::line_t  data_i,
    input  cache_geom_pkg::tag_t   tag_i,
    output cache_geom_pkg::line_t  data_o,
    output cache_geom_pkg::tag_t   tag_o
);
    import cache_geom_pkg::*;

    line_t data_mem [num_sets];
    tag_t  tag_mem  [num_sets];
    line_t merged;

    // byte merge of incoming line over stored line
    always_comb begin
        merged = data_mem[set_i];
        for (int b = 0; b < line_bytes; b++) begin
            if (bmask_i[b]) begin
                merged[8*b +: 8] = data_i[8*b +: 8];
            end
        end
    end

    // registered read, write-first so a fresh fill is visible next cycle
    always_ff @(posedge clk) begin
        if (data_we_i) begin
            data_mem[set_i] <= merged;
            data_o          <= merged;
        end else begin
            data_o <= data_mem[set_i];
        end
        if (tag_we_i) begin
            tag_mem[set_i] <= tag_i;
            tag_o          <= tag_i;
        end else begin
            tag_o <= tag_mem[set_i];
        end
    end

endmodule

`default_nettype wire

// ==== rtl/cache_line_state.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_line_state (
    input  logic                       clk,
    input  logic                       reset_i,
    input  cache_geom_pkg::set_t       set_i,
    input  cache_bus_pkg::line_op_e    dirty_op_i,
    input  cache_bus_pkg::line_op_e    valid_op_i,
    input  cache_geom_pkg::way_t       dirty_way_i,
    input  cache_geom_pkg::way_map_t   hit_map_i,
    input  logic                       plru_update_i,
    output cache_geom_pkg::way_map_t   valid_o,
    output logic                       dirty_o,
    output cache_geom_pkg::way_t       plru_way_o,
    output cache_geom_pkg::way_map_t   plru_map_o
);
    import cache_geom_pkg::*;
    import cache_bus_pkg::*;

    logic [num_sets-1:0][num_ways-1:0] valid_q;
    logic [num_sets-1:0][num_ways-1:0] dirty_q;
    // tree bits per set, {b2, b1, b0}
    logic [num_sets-1:0][2:0]          plru_q;
    logic [2:0]                        tree;
    logic [2:0]                        tree_next;
    way_t                              hit_way;

    assign tree    = plru_q[set_i];
    assign valid_o = valid_q[set_i];

    // dirty only counts on a valid line
    assign dirty_o = dirty_q[set_i][dirty_way_i] & valid_q[set_i][dirty_way_i];

    // b0 picks the half, b1 or b2 picks inside it
    assign plru_way_o = tree[0] ? {1'b1, tree[2]} : {1'b0, tree[1]};
    assign plru_map_o = way_map_t'(1) << plru_way_o;

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < num_ways; w++) begin
            if (hit_map_i[w]) begin
                hit_way = way_t'(w);
            end
        end
    end

    // point the path bits away from the accessed way
    always_comb begin
        tree_next = tree;
        if (hit_way[1]) begin
            tree_next[0] = 1'b0;
            tree_next[2] = ~hit_way[0];
        end else begin
            tree_next[0] = 1'b1;
            tree_next[1] = ~hit_way[0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= '0;
            dirty_q <= '0;
            plru_q  <= '0;
        end else begin
            // valid ops always land on the victim way
            case (valid_op_i)
                line_set:   valid_q[set_i][plru_way_o] <= 1'b1;
                line_clear: valid_q[set_i][plru_way_o] <= 1'b0;
                default:    ;
            endcase
            case (dirty_op_i)
                line_set:   dirty_q[set_i][dirty_way_i] <= 1'b1;
                line_clear: dirty_q[set_i][dirty_way_i] <= 1'b0;
                default:    ;
            endcase
            if (plru_update_i) begin
                plru_q[set_i] <= tree_next;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/cache_datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_datapath (
    input  logic                     clk,
    input  cache_bus_pkg::cpu_cmd_t  cpu_cmd_i,
    input  cache_geom_pkg::line_t    mem_rdata_i,
    input  cache_bus_pkg::dp_ctrl_t  ctrl_i,
    input  cache_geom_pkg::way_map_t valid_i,
    input  cache_geom_pkg::way_t     plru_way_i,
    input  cache_geom_pkg::way_map_t plru_map_i,
    output logic                     hit_o,
    output cache_geom_pkg::way_map_t hit_map_o,
    output cache_geom_pkg::way_t     dirty_way_o,
    output cache_geom_pkg::line_t    line_o,
    output cache_geom_pkg::addr_u    mem_addr_o
);
    import cache_geom_pkg::*;
    import cache_bus_pkg::*;

    tag_t     req_tag;
    set_t     req_set;
    tag_t     tag_rd  [num_ways];
    line_t    data_rd [num_ways];
    way_map_t hit_map;
    way_map_t data_we;
    way_map_t tag_we;
    bmask_t   wmask;
    line_t    din;
    way_t     hit_way;
    way_t     out_way;

    // request address seen as fields
    assign req_tag = cpu_cmd_i.addr.f.tag;
    assign req_set = cpu_cmd_i.addr.f.set;

    for (genvar w = 0; w < num_ways; w++) begin : g_way
        cache_way_array way_inst (
            .clk       (clk),
            .data_we_i (data_we[w]),
            .tag_we_i  (tag_we[w]),
            .set_i     (req_set),
            .bmask_i   (wmask),
            .data_i    (din),
            .tag_i     (req_tag),
            .data_o    (data_rd[w]),
            .tag_o     (tag_rd[w])
        );
    end

    // tag compare, qualified by valid
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < num_ways; w++) begin
            hit_map[w] = valid_i[w] && (tag_rd[w] == req_tag);
            if (hit_map[w]) begin
                hit_way = way_t'(w);
            end
        end
    end

    assign hit_map_o = hit_map;
    assign hit_o     = |hit_map;

    always_comb begin
        // write hit uses the hit way, refill uses the victim
        case (ctrl_i.data_we_sel)
            dwe_hit:    data_we = hit_map;
            dwe_victim: data_we = plru_map_i;
            default:    data_we = '0;
        endcase
        // tags only change on refill
        tag_we = ctrl_i.tag_we ? plru_map_i : '0;
        wmask  = ctrl_i.mask_en ? cpu_cmd_i.bmask : '1;
        din    = (ctrl_i.din_sel == din_mem) ? mem_rdata_i : cpu_cmd_i.wdata;
        // same way feeds the output line and the dirty bit
        out_way = (ctrl_i.out_way_sel == out_victim) ? plru_way_i : hit_way;
    end

    assign dirty_way_o = out_way;
    assign line_o      = data_rd[out_way];

    always_comb begin
        if (ctrl_i.addr_sel == addr_victim) begin
            // writeback goes to the victim's own line
            mem_addr_o.f.tag    = tag_rd[plru_way_i];
            mem_addr_o.f.set    = req_set;
            mem_addr_o.f.offset = '0;
        end else begin
            mem_addr_o.flat = {cpu_cmd_i.addr.flat[31:offset_bits], {offset_bits{1'b0}}};
        end
    end

endmodule

`default_nettype wire

// ==== rtl/cache_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_control (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    cpu_req_i,
    input  logic                    cpu_write_i,
    output logic                    cpu_ack_o,
    output logic                    mem_req_o,
    output logic                    mem_write_o,
    input  logic                    mem_ack_i,
    input  logic                    hit_i,
    input  logic                    victim_dirty_i,
    output cache_bus_pkg::dp_ctrl_t ctrl_o
);
    import cache_bus_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_respond,
        st_writeback,
        st_allocate,
        st_wait_release
    } state_e;

    state_e state_q;
    state_e state_d;
    // set once memory acked, waiting for its ack to fall
    logic   mem_drop_q;
    logic   mem_drop_d;

    assign cpu_ack_o   = (state_q == st_wait_release);
    assign mem_write_o = (state_q == st_writeback);
    assign mem_req_o   = ((state_q == st_writeback) || (state_q == st_allocate)) && !mem_drop_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q    <= st_idle;
            mem_drop_q <= 1'b0;
        end else begin
            state_q    <= state_d;
            mem_drop_q <= mem_drop_d;
        end
    end

    always_comb begin
        state_d    = state_q;
        mem_drop_d = mem_drop_q;
        // idle bundle, nothing written
        ctrl_o = '{
            data_we_sel: dwe_none,
            tag_we:      1'b0,
            din_sel:     din_cpu,
            out_way_sel: out_hit,
            addr_sel:    addr_req,
            mask_en:     1'b0,
            dirty_op:    line_idle,
            valid_op:    line_idle,
            plru_update: 1'b0
        };
        case (state_q)
            st_idle: begin
                if (cpu_req_i) begin
                    state_d = st_lookup;
                end
            end
            st_lookup: begin
                // dirty bit looked up on the victim in case of a miss
                ctrl_o.out_way_sel = out_victim;
                if (hit_i) begin
                    state_d = st_respond;
                end else if (victim_dirty_i) begin
                    state_d = st_writeback;
                end else begin
                    state_d = st_allocate;
                end
            end
            st_respond: begin
                ctrl_o.plru_update = 1'b1;
                if (cpu_write_i) begin
                    ctrl_o.data_we_sel = dwe_hit;
                    ctrl_o.mask_en     = 1'b1;
                    ctrl_o.dirty_op    = line_set;
                end
                state_d = st_wait_release;
            end
            st_writeback: begin
                // victim line out to its own address
                ctrl_o.out_way_sel = out_victim;
                ctrl_o.addr_sel    = addr_victim;
                if (!mem_drop_q && mem_ack_i) begin
                    mem_drop_d = 1'b1;
                end else if (mem_drop_q && !mem_ack_i) begin
                    mem_drop_d = 1'b0;
                    state_d    = st_allocate;
                end
            end
            st_allocate: begin
                ctrl_o.out_way_sel = out_victim;
                if (!mem_drop_q && mem_ack_i) begin
                    // refill strobe while read data is valid
                    ctrl_o.data_we_sel = dwe_victim;
                    ctrl_o.tag_we      = 1'b1;
                    ctrl_o.din_sel     = din_mem;
                    ctrl_o.valid_op    = line_set;
                    ctrl_o.dirty_op    = line_clear;
                    mem_drop_d         = 1'b1;
                end else if (mem_drop_q && !mem_ack_i) begin
                    mem_drop_d = 1'b0;
                    // retry the lookup, now a hit
                    state_d    = st_lookup;
                end
            end
            st_wait_release: begin
                if (!cpu_req_i) begin
                    state_d = st_idle;
                end
            end
            default: state_d = st_idle;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/cache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_top (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    cpu_req_i,
    input  cache_bus_pkg::cpu_cmd_t cpu_cmd_i,
    output logic                    cpu_ack_o,
    output cache_geom_pkg::line_t   cpu_rdata_o,
    output logic                    mem_req_o,
    output cache_bus_pkg::mem_cmd_t mem_cmd_o,
    input  logic                    mem_ack_i,
    input  cache_geom_pkg::line_t   mem_rdata_i
);
    import cache_geom_pkg::*;
    import cache_bus_pkg::*;

    dp_ctrl_t ctrl;
    logic     hit;
    logic     victim_dirty;
    logic     mem_write;
    way_map_t hit_map;
    way_map_t valid;
    way_map_t plru_map;
    way_t     dirty_way;
    way_t     plru_way;
    line_t    line;
    addr_u    mem_addr;

    // one line bus feeds both the cpu read and the writeback
    assign cpu_rdata_o = line;
    assign mem_cmd_o   = '{addr: mem_addr, write: mem_write, wdata: line};

    cache_control control_inst (
        .clk            (clk),
        .reset_i        (reset_i),
        .cpu_req_i      (cpu_req_i),
        .cpu_write_i    (cpu_cmd_i.write),
        .cpu_ack_o      (cpu_ack_o),
        .mem_req_o      (mem_req_o),
        .mem_write_o    (mem_write),
        .mem_ack_i      (mem_ack_i),
        .hit_i          (hit),
        .victim_dirty_i (victim_dirty),
        .ctrl_o         (ctrl)
    );

    cache_datapath datapath_inst (
        .clk         (clk),
        .cpu_cmd_i   (cpu_cmd_i),
        .mem_rdata_i (mem_rdata_i),
        .ctrl_i      (ctrl),
        .valid_i     (valid),
        .plru_way_i  (plru_way),
        .plru_map_i  (plru_map),
        .hit_o       (hit),
        .hit_map_o   (hit_map),
        .dirty_way_o (dirty_way),
        .line_o      (line),
        .mem_addr_o  (mem_addr)
    );

    cache_line_state line_state_inst (
        .clk           (clk),
        .reset_i       (reset_i),
        .set_i         (cpu_cmd_i.addr.f.set),
        .dirty_op_i    (ctrl.dirty_op),
        .valid_op_i    (ctrl.valid_op),
        .dirty_way_i   (dirty_way),
        .hit_map_i     (hit_map),
        .plru_update_i (ctrl.plru_update),
        .valid_o       (valid),
        .dirty_o       (victim_dirty),
        .plru_way_o    (plru_way),
        .plru_map_o    (plru_map)
    );

endmodule

`default_nettype wire

// ==== testbench/cache_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_asserts (
    input logic                    clk,
    input logic                    reset_i,
    input logic                    cpu_req_i,
    input logic                    cpu_ack_i,
    input logic                    mem_req_i,
    input logic                    mem_ack_i,
    input cache_bus_pkg::mem_cmd_t mem_cmd_i
);

    // cpu ack only answers a live request
    cpu_ack_needs_req: assert property (@(posedge clk) disable iff (reset_i)
        $rose(cpu_ack_i) |-> cpu_req_i)
        else $error("cpu_ack rose while cpu_req was low");

    // command frozen until memory answers
    mem_cmd_held: assert property (@(posedge clk) disable iff (reset_i)
        mem_req_i && $past(mem_req_i && !mem_ack_i) |-> $stable(mem_cmd_i))
        else $error("mem_cmd changed while mem_req waited for mem_ack");

    // memory handshake fully closed while the cpu holds a response
    no_mem_during_ack: assert property (@(posedge clk) disable iff (reset_i)
        cpu_ack_i |-> !mem_req_i && !mem_ack_i)
        else $error("memory handshake still active while cpu_ack high");

    // four-phase release order on both ports
    cpu_ack_falls_late: assert property (@(posedge clk) disable iff (reset_i)
        $fell(cpu_ack_i) |-> !cpu_req_i)
        else $error("cpu_ack fell before cpu_req");
    mem_ack_falls_late: assert property (@(posedge clk) disable iff (reset_i)
        $fell(mem_ack_i) |-> !mem_req_i)
        else $error("mem_ack fell before mem_req");

endmodule

bind cache_top cache_asserts asserts_inst (
    .clk       (clk),
    .reset_i   (reset_i),
    .cpu_req_i (cpu_req_i),
    .cpu_ack_i (cpu_ack_o),
    .mem_req_i (mem_req_o),
    .mem_ack_i (mem_ack_i),
    .mem_cmd_i (mem_cmd_o)
);

`default_nettype wire

// ==== testbench/cache_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_tb;
    import cache_geom_pkg::*;
    import cache_bus_pkg::*;

    localparam int   ack_timeout = 100;
    localparam set_t test_set    = 4'h5;

    logic     clk = 1'b0;
    logic     reset;
    logic     cpu_req;
    cpu_cmd_t cpu_cmd;
    logic     cpu_ack;
    line_t    cpu_rdata;
    logic     mem_req;
    mem_cmd_t mem_cmd;
    logic     mem_ack = 1'b0;
    line_t    mem_rdata = '0;

    // memory model state and request log
    line_t       mem_store [logic [31:0]];
    logic [31:0] fill_salt = '0;
    logic        mem_pending = 1'b0;
    int          mem_delay = 0;
    int          read_count = 0;
    addr_u       log_addr [$];
    logic        log_write [$];
    line_t       log_data [$];

    // reference copy of one set
    tag_t                m_tag [num_ways];
    line_t               m_data [num_ways];
    logic [num_ways-1:0] m_valid;
    logic [num_ways-1:0] m_dirty;
    logic [2:0]          m_tree;

    int   mismatch_count = 0;
    int   timeout_count = 0;
    logic aborted = 1'b0;
    addr_u addr_a;
    addr_u addr_e;

    always #20 clk = ~clk;

    cache_top cache_top_inst (
        .clk         (clk),
        .reset_i     (reset),
        .cpu_req_i   (cpu_req),
        .cpu_cmd_i   (cpu_cmd),
        .cpu_ack_o   (cpu_ack),
        .cpu_rdata_o (cpu_rdata),
        .mem_req_o   (mem_req),
        .mem_cmd_o   (mem_cmd),
        .mem_ack_i   (mem_ack),
        .mem_rdata_i (mem_rdata)
    );

    // untouched lines, hashed from the full address
    function automatic line_t fill_line(input logic [31:0] a);
        line_t l;
        for (int i = 0; i < 8; i++) begin
            l[32*i +: 32] = ((a ^ fill_salt) + 32'(i)) * 32'h9e37_79b9;
        end
        return l;
    endfunction

    function automatic line_t stored_line(input logic [31:0] a);
        return mem_store.exists(a) ? mem_store[a] : fill_line(a);
    endfunction

    function automatic line_t rand_line();
        line_t l;
        for (int i = 0; i < 8; i++) begin
            l[32*i +: 32] = $urandom;
        end
        return l;
    endfunction

    function automatic line_t merge_line(input line_t old, input line_t nw, input bmask_t m);
        line_t l;
        l = old;
        for (int b = 0; b < line_bytes; b++) begin
            if (m[b]) begin
                l[8*b +: 8] = nw[8*b +: 8];
            end
        end
        return l;
    endfunction

    // b0 picks the half, b1 or b2 the way inside it
    function automatic way_t victim_of(input logic [2:0] tree);
        if (tree[0]) begin
            return tree[2] ? 2'd3 : 2'd2;
        end
        return tree[1] ? 2'd1 : 2'd0;
    endfunction

    function automatic logic [2:0] touch_way(input logic [2:0] tree, input way_t way);
        logic [2:0] t;
        t = tree;
        t[0] = ~way[1];
        if (way[1]) begin
            t[2] = ~way[0];
        end else begin
            t[1] = ~way[0];
        end
        return t;
    endfunction

    function automatic addr_u make_addr(input tag_t tag);
        addr_u a;
        a.f.tag    = tag;
        a.f.set    = test_set;
        a.f.offset = 5'h0c;
        return a;
    endfunction

    // memory side, 1 to 5 cycles to answer
    always @(posedge clk) begin
        if (reset) begin
            mem_ack     <= 1'b0;
            mem_pending <= 1'b0;
            mem_delay   <= 0;
        end else if (mem_ack) begin
            if (!mem_req) begin
                mem_ack <= 1'b0;
            end
        end else if (mem_req && !mem_pending) begin
            mem_pending <= 1'b1;
            mem_delay   <= $urandom_range(4, 0);
        end else if (mem_req && mem_delay != 0) begin
            mem_delay <= mem_delay - 1;
        end else if (mem_req) begin
            $display("memory %s at %h", mem_cmd.write ? "write" : "read", mem_cmd.addr.flat);
            log_addr.push_back(mem_cmd.addr);
            log_write.push_back(mem_cmd.write);
            log_data.push_back(mem_cmd.wdata);
            if (mem_cmd.write) begin
                mem_store[mem_cmd.addr.flat] = mem_cmd.wdata;
            end else begin
                mem_rdata  <= stored_line(mem_cmd.addr.flat);
                read_count <= read_count + 1;
            end
            mem_ack     <= 1'b1;
            mem_pending <= 1'b0;
        end
    end

    task automatic check_line(input string name, input line_t exp, input line_t act);
        if (exp !== act) begin
            $display("MISMATCH %s: expected %h, actual %h", name, exp, act);
            mismatch_count++;
        end
    endtask

    task automatic check_addr(input string name, input addr_u exp, input addr_u act);
        if (exp !== act) begin
            $display("MISMATCH %s: expected %h, actual %h", name, exp.flat, act.flat);
            mismatch_count++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("MISMATCH %s: expected %b, actual %b", name, exp, act);
            mismatch_count++;
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (exp != act) begin
            $display("MISMATCH %s: expected %0d, actual %0d", name, exp, act);
            mismatch_count++;
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        reset <= 1'b1;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
    endtask

    task automatic clear_model();
        m_valid = '0;
        m_dirty = '0;
        m_tree  = '0;
        for (int w = 0; w < num_ways; w++) begin
            m_tag[w]  = '0;
            m_data[w] = '0;
        end
    endtask

    // one four-phase cpu transaction, latency counted from the edge that sees req
    task automatic cpu_access(input addr_u addr, input logic write, input bmask_t mask,
                              input line_t wdata, output line_t rdata, output int latency);
        int cycles;
        rdata   = '0;
        latency = 0;
        cycles  = 0;
        if (aborted) begin
            return;
        end
        @(posedge clk);
        cpu_cmd <= '{addr: addr, write: write, bmask: mask, wdata: wdata};
        cpu_req <= 1'b1;
        while (!cpu_ack && cycles < ack_timeout) begin
            @(posedge clk);
            cycles++;
        end
        if (!cpu_ack) begin
            $display("timeout: no cpu acknowledge for address %h", addr.flat);
            timeout_count++;
            aborted = 1'b1;
            return;
        end
        // ack seen one edge after it rose
        latency = cycles - 2;
        rdata   = cpu_rdata;
        cpu_req <= 1'b0;
        cycles  = 0;
        while (cpu_ack && cycles < ack_timeout) begin
            @(posedge clk);
            cycles++;
        end
        if (cpu_ack) begin
            $display("timeout: cpu acknowledge stayed high after the request dropped");
            timeout_count++;
            aborted = 1'b1;
        end
    endtask

    // predicts hit or victim, runs the access, checks data and memory traffic
    task automatic model_access(input string name, input addr_u addr, input logic write,
                                input bmask_t mask, input line_t wdata, output int latency);
        addr_u line_addr;
        addr_u wb_addr;
        way_t  way;
        logic  hit;
        logic  wb;
        line_t wb_data;
        line_t expected;
        line_t got;
        int    base;
        int    n_exp;
        line_addr          = addr;
        line_addr.f.offset = '0;
        hit     = 1'b0;
        wb      = 1'b0;
        way     = '0;
        wb_addr = '0;
        wb_data = '0;
        for (int w = 0; w < num_ways; w++) begin
            if (m_valid[w] && m_tag[w] == addr.f.tag) begin
                hit = 1'b1;
                way = way_t'(w);
            end
        end
        if (!hit) begin
            way           = victim_of(m_tree);
            wb            = m_valid[way] && m_dirty[way];
            wb_addr.f.tag = m_tag[way];
            wb_addr.f.set = test_set;
            wb_data       = m_data[way];
            m_tag[way]    = addr.f.tag;
            m_valid[way]  = 1'b1;
            m_dirty[way]  = 1'b0;
            m_data[way]   = stored_line(line_addr.flat);
        end
        if (write) begin
            m_data[way]  = merge_line(m_data[way], wdata, mask);
            m_dirty[way] = 1'b1;
        end
        m_tree   = touch_way(m_tree, way);
        expected = m_data[way];
        n_exp    = hit ? 0 : (wb ? 2 : 1);
        base     = log_addr.size();
        cpu_access(addr, write, mask, wdata, got, latency);
        if (aborted) begin
            return;
        end
        check_line({name, " data"}, expected, got);
        check_count({name, " memory requests"}, n_exp, log_addr.size() - base);
        if (n_exp != 0 && log_addr.size() - base == n_exp) begin
            if (wb) begin
                check_flag({name, " writeback flag"}, 1'b1, log_write[base]);
                check_addr({name, " writeback address"}, wb_addr, log_addr[base]);
                check_line({name, " writeback data"}, wb_data, log_data[base]);
                base++;
            end
            check_flag({name, " refill flag"}, 1'b0, log_write[base]);
            check_addr({name, " refill address"}, line_addr, log_addr[base]);
        end
    endtask

    task automatic test_cold_read_miss();
        int lat;
        int reads;
        reads = read_count;
        model_access("cold read miss", addr_a, 1'b0, '0, '0, lat);
        if (!aborted) begin
            check_count("cold read miss reads", reads + 1, read_count);
        end
    endtask

    task automatic test_read_hit();
        int lat;
        model_access("read hit", addr_a, 1'b0, '0, '0, lat);
        if (!aborted) begin
            check_count("read hit latency", 2, lat);
        end
    endtask

    task automatic test_masked_write();
        int lat;
        model_access("masked write hit", addr_a, 1'b1, bmask_t'($urandom), rand_line(), lat);
        model_access("masked write readback", addr_a, 1'b0, '0, '0, lat);
    endtask

    // walk the victim order through dirty and clean evictions
    task automatic test_eviction();
        int lat;
        model_access("evict write b", make_addr(23'h00_0b01), 1'b1, bmask_t'($urandom),
                     rand_line(), lat);
        model_access("evict read c", make_addr(23'h00_0c02), 1'b0, '0, '0, lat);
        model_access("evict write d", make_addr(23'h00_0d03), 1'b1, '1, rand_line(), lat);
        model_access("evict read e", addr_e, 1'b0, '0, '0, lat);
        model_access("evict read f", make_addr(23'h00_0f05), 1'b0, '0, '0, lat);
        model_access("evict reread a", addr_a, 1'b0, '0, '0, lat);
        // refilled over a dirty line, so the later victim must be clean
        model_access("evict read g", make_addr(23'h00_0107), 1'b0, '0, '0, lat);
        model_access("evict read h", make_addr(23'h00_0108), 1'b0, '0, '0, lat);
    endtask

    task automatic test_reset_clears();
        int lat;
        int reads;
        apply_reset();
        clear_model();
        reads = read_count;
        model_access("read after reset", addr_a, 1'b0, '0, '0, lat);
        if (!aborted) begin
            check_count("read after reset reads", reads + 1, read_count);
        end
    endtask

    initial begin
        fill_salt = $urandom(32'h0635_5164);
        cpu_req   = 1'b0;
        cpu_cmd   = '0;
        reset     = 1'b1;
        addr_a    = make_addr(23'h00_0a00);
        addr_e    = make_addr(23'h00_0e04);
        clear_model();
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        test_cold_read_miss();
        test_read_hit();
        test_masked_write();
        test_eviction();
        test_reset_clears();
        $display("errors: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
        if (mismatch_count == 0 && timeout_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
rtl/cache_geom_pkg.sv
rtl/cache_bus_pkg.sv
rtl/cache_way_array.sv
rtl/cache_line_state.sv
rtl/cache_datapath.sv
rtl/cache_control.sv
rtl/cache_top.sv
testbench/cache_asserts.sv
testbench/cache_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with Verilator and run; pass is found by searching the simulation output

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module cache_tb \
    -f tb.f -o cache_sim &&
./obj_dir/cache_sim | tee /dev/stderr | grep -q "Test completed successfully" &&
echo "RESULT: PASS" ||
{ echo "RESULT: FAIL"; exit 1; }
